//--- verilog/dzCorePkg.sv
package dzCorePkg;

  typedef logic [7:0]  tData;
  typedef logic [15:0] tAddr;
  typedef logic [2:0]  tRegIdx;   // B C D E H L (HL) A
  typedef logic [2:0]  tAluOp;
  typedef logic [2:0]  tOpClass;

  localparam tAluOp aluAdd  = 3'd0;
  localparam tAluOp aluSub  = 3'd1;
  localparam tAluOp aluAnd  = 3'd2;
  localparam tAluOp aluXor  = 3'd3;
  localparam tAluOp aluOr   = 3'd4;
  localparam tAluOp aluInc  = 3'd5;
  localparam tAluOp aluDec  = 3'd6;
  localparam tAluOp aluPass = 3'd7;

  localparam tOpClass opNop     = 3'd0;
  localparam tOpClass opLoadReg = 3'd1;
  localparam tOpClass opLoadImm = 3'd2;
  localparam tOpClass opAlu     = 3'd3;
  localparam tOpClass opStore   = 3'd4;
  localparam tOpClass opJump    = 3'd5;
  localparam tOpClass opHalt    = 3'd6;

  // ----------------------------------------
  // Opcode fields

  localparam logic [1:0] grpMisc = 2'b00;
  localparam logic [1:0] grpLoad = 2'b01;
  localparam logic [1:0] grpAlu  = 2'b10;
  localparam logic [1:0] grpJump = 2'b11;

  localparam tRegIdx regIdxH  = 3'd4;
  localparam tRegIdx regIdxL  = 3'd5;
  localparam tRegIdx regIdxHl = 3'd6;
  localparam tRegIdx regIdxA  = 3'd7;

  typedef struct packed {
    logic z;
    logic n;
    logic h;
    logic c;
  } tFlags;

  typedef struct packed {
    tOpClass    opClass;
    tRegIdx     dstReg;
    tRegIdx     srcReg;
    tAluOp      aluOp;
    logic [1:0] condCode;   // NZ Z NC C
    logic       condUsed;
  } tDecodedOp;

  typedef struct packed {
    logic readRequest;
    logic writeEnable;
    tAddr addr;
    tData writeData;
  } tMemRequest;

  typedef enum logic [2:0] {
    sFetch,
    sExec,
    sOperandReq,
    sOperandCap,
    sTargetReq,
    sTargetCap,
    sStore,
    sHalt
  } tSeqState;

  localparam tData flagsResetValue = 8'hB0;   // Flags live in the high nibble

endpackage

//--- verilog/opcodeDecoder.sv
module opcodeDecoder
(
  input  logic                 iClock,
  input  logic                 rst,
  input  dzCorePkg::tData      readData,
  input  logic                 capture,
  output dzCorePkg::tDecodedOp decoded
);
  import dzCorePkg::*;

  logic       captureCycle;
  tData       opcodeReg;
  tData       opcode;
  logic [1:0] group;
  tRegIdx     dst;
  tRegIdx     src;

  // Opcode arrives one cycle after the fetch strobe
  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      captureCycle <= 1'b0;
      opcodeReg    <= '0;
    end
    else
    begin
      captureCycle <= capture;
      if (captureCycle)
        opcodeReg <= readData;
    end
  end

  assign opcode = captureCycle ? readData : opcodeReg;   // Bypass during capture
  assign group  = opcode[7:6];
  assign dst    = opcode[5:3];
  assign src    = opcode[2:0];

  always_comb
  begin
    decoded          = '0;
    decoded.opClass  = opNop;
    decoded.dstReg   = dst;
    decoded.srcReg   = src;
    decoded.aluOp    = aluPass;
    decoded.condCode = opcode[4:3];
    case (group)
      grpMisc:
      begin
        if (dst != regIdxHl)
        begin
          decoded.srcReg = dst;   // INC and DEC work on the destination
          case (src)
            3'b110: decoded.opClass = opLoadImm;
            3'b100:
            begin
              decoded.opClass = opAlu;
              decoded.aluOp   = aluInc;
            end
            3'b101:
            begin
              decoded.opClass = opAlu;
              decoded.aluOp   = aluDec;
            end
            default: decoded.opClass = opNop;
          endcase
        end
      end
      grpLoad:
      begin
        if (dst == regIdxHl && src == regIdxHl)
          decoded.opClass = opHalt;
        else if (dst == regIdxHl)
          decoded.opClass = opStore;
        else if (src != regIdxHl)
          decoded.opClass = opLoadReg;
      end
      grpAlu:
      begin
        decoded.dstReg = regIdxA;
        case (dst)
          3'b000:  decoded.aluOp = aluAdd;
          3'b010:  decoded.aluOp = aluSub;
          3'b100:  decoded.aluOp = aluAnd;
          3'b101:  decoded.aluOp = aluXor;
          3'b110:  decoded.aluOp = aluOr;
          default: decoded.aluOp = aluPass;   // ADC SBC CP
        endcase
        if (decoded.aluOp != aluPass && src != regIdxHl)
          decoded.opClass = opAlu;
      end
      default:
      begin
        if (opcode == 8'hC3)
          decoded.opClass = opJump;
        else if (opcode[7:5] == 3'b110 && src == 3'b010)
        begin
          decoded.opClass  = opJump;
          decoded.condUsed = 1'b1;
        end
      end
    endcase
  end

endmodule

//--- verilog/sequencer.sv
module sequencer
(
  input  logic                 iClock,
  input  logic                 rst,
  input  dzCorePkg::tDecodedOp decoded,
  input  dzCorePkg::tFlags     flags,
  output logic                 regWrite,
  output logic                 flagsWrite,
  output logic                 fetch,
  output logic                 operandFetch,
  output logic                 store,
  output logic                 loadPc,
  output logic                 captureOperand,
  output logic                 halted
);
  import dzCorePkg::*;

  tSeqState state;
  tSeqState nextState;
  logic     condMet;
  logic     jumpTaken;

  // Reset parks in fetch, so the first cycle after reset reads resetPc
  always_ff @(posedge iClock)
  begin
    if (rst)
      state <= sFetch;
    else
      state <= nextState;
  end

  always_comb
  begin
    case (decoded.condCode)
      2'b00:   condMet = !flags.z;
      2'b01:   condMet = flags.z;
      2'b10:   condMet = !flags.c;
      default: condMet = flags.c;
    endcase
  end

  assign jumpTaken = !decoded.condUsed || condMet;

  // ----------------------------------------
  always_comb
  begin
    nextState = state;
    case (state)
      sFetch: nextState = sExec;
      sExec:
      begin
        case (decoded.opClass)
          opLoadImm: nextState = sOperandReq;
          opJump:    nextState = sOperandReq;
          opStore:   nextState = sStore;
          opHalt:    nextState = sHalt;
          default:   nextState = sFetch;
        endcase
      end
      sOperandReq: nextState = sOperandCap;
      sOperandCap: nextState = (decoded.opClass == opJump) ? sTargetReq : sFetch;
      sTargetReq:  nextState = sTargetCap;
      sTargetCap:  nextState = sFetch;
      sStore:      nextState = sFetch;
      default:     nextState = sHalt;   // Only reset leaves
    endcase
  end

  assign fetch          = (state == sFetch) && !rst;   // Bus quiet during reset
  assign operandFetch   = (state == sOperandReq) || (state == sTargetReq);
  assign captureOperand = (state == sOperandCap) && (decoded.opClass == opJump);
  assign loadPc         = (state == sTargetCap) && jumpTaken;
  assign store          = (state == sStore);
  assign halted         = (state == sHalt);

  assign regWrite = (state == sExec && (decoded.opClass == opLoadReg ||
                                        decoded.opClass == opAlu)) ||
                    (state == sOperandCap && decoded.opClass == opLoadImm);

  assign flagsWrite = (state == sExec) && (decoded.opClass == opAlu);

endmodule

//--- verilog/registerFile.sv
module registerFile
(
  input  logic              iClock,
  input  logic              rst,
  input  logic              writeEnable,
  input  dzCorePkg::tRegIdx writeIdx,
  input  dzCorePkg::tData   writeData,
  input  logic              flagsWrite,
  input  dzCorePkg::tFlags  flagsIn,
  input  dzCorePkg::tRegIdx readIdxA,
  input  dzCorePkg::tRegIdx readIdxB,
  output dzCorePkg::tData   readA,
  output dzCorePkg::tData   readB,
  output dzCorePkg::tData   accumulator,
  output dzCorePkg::tData   regH,
  output dzCorePkg::tData   regL,
  output dzCorePkg::tFlags  flags
);
  import dzCorePkg::*;

  tData regs [8];   // Slot 6 is (HL), never written

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
      flags <= flagsResetValue[7:4];
    end
    else
    begin
      if (writeEnable && writeIdx != regIdxHl)
        regs[writeIdx] <= writeData;
      if (flagsWrite)
        flags <= flagsIn;
    end
  end

  assign readA       = regs[readIdxA];
  assign readB       = regs[readIdxB];
  assign accumulator = regs[regIdxA];
  assign regH        = regs[regIdxH];
  assign regL        = regs[regIdxL];

endmodule

//--- verilog/aluFlags.sv
module aluFlags
(
  input  dzCorePkg::tData      accumulator,
  input  dzCorePkg::tData      operand,
  input  dzCorePkg::tData      immediate,
  input  dzCorePkg::tDecodedOp decoded,
  input  dzCorePkg::tFlags     flagsIn,
  output dzCorePkg::tData      result,
  output dzCorePkg::tFlags     flagsOut
);
  import dzCorePkg::*;

  logic [4:0] halfSum;
  logic [4:0] halfDiff;
  logic [8:0] fullSum;
  logic [8:0] fullDiff;

  assign halfSum  = {1'b0, accumulator[3:0]} + {1'b0, operand[3:0]};
  assign halfDiff = {1'b0, accumulator[3:0]} - {1'b0, operand[3:0]};   // Borrow into bit 4
  assign fullSum  = {1'b0, accumulator} + {1'b0, operand};
  assign fullDiff = {1'b0, accumulator} - {1'b0, operand};

  always_comb
  begin
    result   = operand;
    flagsOut = flagsIn;
    case (decoded.aluOp)
      aluAdd:
      begin
        result   = fullSum[7:0];
        flagsOut = '{z: 1'b0, n: 1'b0, h: halfSum[4], c: fullSum[8]};
      end
      aluSub:
      begin
        result   = fullDiff[7:0];
        flagsOut = '{z: 1'b0, n: 1'b1, h: halfDiff[4], c: fullDiff[8]};
      end
      aluAnd:
      begin
        result   = accumulator & operand;
        flagsOut = '{z: 1'b0, n: 1'b0, h: 1'b1, c: 1'b0};
      end
      aluXor:
      begin
        result   = accumulator ^ operand;
        flagsOut = '{z: 1'b0, n: 1'b0, h: 1'b0, c: 1'b0};
      end
      aluOr:
      begin
        result   = accumulator | operand;
        flagsOut = '{z: 1'b0, n: 1'b0, h: 1'b0, c: 1'b0};
      end
      aluInc:
      begin
        result     = operand + 8'd1;
        flagsOut.n = 1'b0;
        flagsOut.h = (result[3:0] == 4'h0);   // Carry left the low nibble
      end
      aluDec:
      begin
        result     = operand - 8'd1;
        flagsOut.n = 1'b1;
        flagsOut.h = (result[3:0] == 4'hF);
      end
      default: result = (decoded.opClass == opLoadImm) ? immediate : operand;
    endcase
    if (decoded.aluOp != aluPass)
      flagsOut.z = (result == '0);
  end

endmodule

//--- verilog/busInterface.sv
module busInterface
#(
  parameter dzCorePkg::tAddr resetPc = 16'h0000
)
(
  input  logic                  iClock,
  input  logic                  rst,
  input  logic                  fetch,
  input  logic                  operandFetch,
  input  logic                  store,
  input  logic                  loadPc,
  input  logic                  captureOperand,
  input  dzCorePkg::tData       readData,
  input  dzCorePkg::tData       regH,
  input  dzCorePkg::tData       regL,
  input  dzCorePkg::tData       storeData,
  output dzCorePkg::tMemRequest memRequest
);
  import dzCorePkg::*;

  tAddr pc;
  tData targetLow;

  always_ff @(posedge iClock)
  begin
    if (rst)
      pc <= resetPc;
    else if (loadPc)
      pc <= {readData, targetLow};   // High byte straight off the bus
    else if (fetch || operandFetch)
      pc <= pc + 16'd1;
  end

  always_ff @(posedge iClock)
  begin
    if (captureOperand)
      targetLow <= readData;
  end

  always_comb
  begin
    memRequest.readRequest = fetch || operandFetch;
    memRequest.writeEnable = store;
    memRequest.addr        = store ? {regH, regL} : pc;
    memRequest.writeData   = storeData;
  end

endmodule

//--- verilog/dzCoreTop.sv
module dzCoreTop
#(
  parameter dzCorePkg::tAddr resetPc = 16'h0000
)
(
  input  logic                  iClock,
  input  logic                  rst,
  output dzCorePkg::tMemRequest memRequest,
  input  dzCorePkg::tData       readData,
  output logic                  halted
);
  import dzCorePkg::*;

  tDecodedOp decoded;
  tFlags     flags;
  tFlags     newFlags;
  tData      aluResult;
  tData      readA;
  tData      readB;
  tData      accumulator;
  tData      regH;
  tData      regL;
  logic      regWrite;
  logic      flagsWrite;
  logic      fetch;
  logic      operandFetch;
  logic      store;
  logic      loadPc;
  logic      captureOperand;

  // ----------------------------------------
  // Input side
  opcodeDecoder decoder
  (
    .iClock   (iClock),
    .rst      (rst),
    .readData (readData),
    .capture  (fetch),
    .decoded  (decoded)
  );

  // ----------------------------------------
  // Processing
  sequencer control
  (
    .iClock         (iClock),
    .rst            (rst),
    .decoded        (decoded),
    .flags          (flags),
    .regWrite       (regWrite),
    .flagsWrite     (flagsWrite),
    .fetch          (fetch),
    .operandFetch   (operandFetch),
    .store          (store),
    .loadPc         (loadPc),
    .captureOperand (captureOperand),
    .halted         (halted)
  );

  registerFile regs
  (
    .iClock      (iClock),
    .rst         (rst),
    .writeEnable (regWrite),
    .writeIdx    (decoded.dstReg),
    .writeData   (aluResult),
    .flagsWrite  (flagsWrite),
    .flagsIn     (newFlags),
    .readIdxA    (decoded.srcReg),
    .readIdxB    (decoded.srcReg),   // Store data for LD (HL),r
    .readA       (readA),
    .readB       (readB),
    .accumulator (accumulator),
    .regH        (regH),
    .regL        (regL),
    .flags       (flags)
  );

  aluFlags alu
  (
    .accumulator (accumulator),
    .operand     (readA),
    .immediate   (readData),
    .decoded     (decoded),
    .flagsIn     (flags),
    .result      (aluResult),
    .flagsOut    (newFlags)
  );

  // ----------------------------------------
  // Output side
  busInterface #(.resetPc(resetPc)) bus
  (
    .iClock         (iClock),
    .rst            (rst),
    .fetch          (fetch),
    .operandFetch   (operandFetch),
    .store          (store),
    .loadPc         (loadPc),
    .captureOperand (captureOperand),
    .readData       (readData),
    .regH           (regH),
    .regL           (regL),
    .storeData      (readB),
    .memRequest     (memRequest)
  );

endmodule

//--- testbench/dzCore_properties.sv
module dzCoreProperties
(
  input logic                  iClock,
  input logic                  rst,
  input dzCorePkg::tMemRequest memRequest,
  input logic                  halted
);
  timeunit 1ns;
  timeprecision 1ps;

  assert property (@(posedge iClock) !(memRequest.readRequest && memRequest.writeEnable))
    else $error("Read and write strobes high together");

  assert property (@(posedge iClock) disable iff (rst) halted |=> halted)
    else $error("halted dropped without reset");

  // Bus stays quiet once halted
  assert property (@(posedge iClock) disable iff (rst)
    halted |-> !memRequest.readRequest && !memRequest.writeEnable)
    else $error("Bus activity while halted");

  assert property (@(posedge iClock)
    rst && $past(rst) |-> !memRequest.readRequest && !memRequest.writeEnable)
    else $error("Bus strobe during reset");

endmodule

bind dzCoreTop dzCoreProperties props
(
  .iClock     (iClock),
  .rst        (rst),
  .memRequest (memRequest),
  .halted     (halted)
);

//--- testbench/dzCoreTb.sv
module dzCoreTb;
  timeunit 1ns;
  timeprecision 1ps;
  import dzCorePkg::*;

  logic       iClock = 1'b0;
  logic       rst;
  tData       readData;
  tMemRequest memRequest;
  logic       halted;

  tData  mem [65536];
  tData  refMem [65536];
  tData  prog [$];
  tAddr  expAddr [$];
  tData  expData [$];
  int    writeIdx;
  int    errorCount;
  string testName;

  always #20 iClock = ~iClock;

  dzCoreTop #(.resetPc(16'h0000)) DUT
  (
    .iClock     (iClock),
    .rst        (rst),
    .memRequest (memRequest),
    .readData   (readData),
    .halted     (halted)
  );

  // ----------------------------------------
  // Memory model, one cycle read latency
  always @(posedge iClock)
  begin
    if (memRequest.readRequest)
      readData <= mem[memRequest.addr];
    if (memRequest.writeEnable)
      mem[memRequest.addr] = memRequest.writeData;
  end

  task automatic abortRun();
    $display("SIMULATION FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic reportFailure(input string msg);
    errorCount++;
    $display("Error in %s: %s", testName, msg);
    abortRun();
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      errorCount++;
      $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
      abortRun();
    end
  endtask

  // Instruction-set model, fills the expected write queues
  function automatic int runReference();
    tData       regs [8];
    tAddr       pc;
    tData       op;
    tData       a;
    tData       b;
    tData       r;
    tData       lo;
    tData       hi;
    logic [8:0] wide;
    logic [2:0] d;
    logic [2:0] s;
    logic       fz;
    logic       fn;
    logic       fh;
    logic       fc;
    logic       taken;
    logic       done;
    int         steps;
    expAddr.delete();
    expData.delete();
    for (int i = 0; i < 8; i++)
      regs[i] = '0;
    {fz, fn, fh, fc} = 4'b1011;   // B0h
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 10000)
    begin
      steps++;
      op = refMem[pc];
      pc = pc + 16'd1;
      d  = op[5:3];
      s  = op[2:0];
      if (op == 8'h76)
        done = 1'b1;
      else if (op[7:6] == 2'b00 && d != 3'd6)
      begin
        if (s == 3'd6)
        begin
          regs[d] = refMem[pc];
          pc      = pc + 16'd1;
        end
        else if (s == 3'd4 || s == 3'd5)
        begin
          r       = s[0] ? regs[d] - 8'd1 : regs[d] + 8'd1;
          fz      = (r == 8'h00);
          fn      = s[0];
          fh      = s[0] ? (r[3:0] == 4'hF) : (r[3:0] == 4'h0);
          regs[d] = r;
        end
      end
      else if (op[7:6] == 2'b01)
      begin
        if (d == 3'd6)
        begin
          expAddr.push_back({regs[4], regs[5]});
          expData.push_back(regs[s]);
          refMem[{regs[4], regs[5]}] = regs[s];
        end
        else if (s != 3'd6)
          regs[d] = regs[s];
      end
      else if (op[7:6] == 2'b10 && s != 3'd6 && d != 3'd1 && d != 3'd3 && d != 3'd7)
      begin
        a = regs[7];
        b = regs[s];
        case (d)
          3'd0:
          begin
            wide = {1'b0, a} + {1'b0, b};
            r    = wide[7:0];
            fn   = 1'b0;
            fh   = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
            fc   = wide[8];
          end
          3'd2:
          begin
            r  = a - b;
            fn = 1'b1;
            fh = a[3:0] < b[3:0];
            fc = a < b;
          end
          3'd4:
          begin
            r = a & b;
            {fn, fh, fc} = 3'b010;
          end
          3'd5:
          begin
            r = a ^ b;
            {fn, fh, fc} = 3'b000;
          end
          default:
          begin
            r = a | b;
            {fn, fh, fc} = 3'b000;
          end
        endcase
        fz      = (r == 8'h00);
        regs[7] = r;
      end
      else if (op == 8'hC3 || (op[7:5] == 3'b110 && s == 3'b010))
      begin
        lo = refMem[pc];
        hi = refMem[pc + 16'd1];
        pc = pc + 16'd2;
        case (op[4:3])
          2'd0:    taken = !fz;
          2'd1:    taken = fz;
          2'd2:    taken = !fc;
          default: taken = fc;
        endcase
        if (op == 8'hC3)
          taken = 1'b1;
        if (taken)
          pc = {hi, lo};
      end
    end
    if (!done)
      return -1;
    return expAddr.size();
  endfunction

  // ----------------------------------------
  // Program builders
  task automatic emit(input tData value);
    prog.push_back(value);
  endtask

  task automatic emitHex(input logic [255:0] v, input int n);
    for (int i = 0; i < n; i++)
      emit(v[8*(n-1-i) +: 8]);
  endtask

  // Store A, then each JP cc either skips a store or not
  task automatic aluCase(input tData a, input tData b, input tData op);
    logic [15:0] target;
    emitHex({8'h3E, a, 8'h06, b, op, 8'h77}, 6);
    for (int cc = 0; cc < 4; cc++)
    begin
      target = 16'(prog.size() + 4);
      emit({3'b110, 2'(cc), 3'b010});
      emit(target[7:0]);
      emit(target[15:8]);
      emit(8'h70 | 8'(cc));
    end
    emit(8'h2C);   // INC L
  endtask

  task automatic buildLoads();
    prog.delete();
    emitHex(112'h0611_0E22_1633_1E44_3E55_2680_2E20, 14);
    emitHex(56'h7071_7273_7475_77, 7);
    emitHex(80'h4748_515A_7B70_7172_7377, 10);
    emitHex(48'h7D6C_7760_7776, 6);
  endtask

  task automatic buildAlu();
    prog.delete();
    emitHex(80'h2680_2E40_0E0C_160D_1E0E, 10);   // Distinct C D E mark the flag stores
    aluCase(8'h0F, 8'h01, 8'h80);   // Half carry
    aluCase(8'hF0, 8'h10, 8'h80);   // Carry to zero
    aluCase(8'h10, 8'h01, 8'h90);
    aluCase(8'h05, 8'h05, 8'h90);
    aluCase(8'h03, 8'h05, 8'h90);   // Borrow
    aluCase(8'hF0, 8'h0F, 8'hA0);
    aluCase(8'hAA, 8'hAA, 8'hA8);
    aluCase(8'h00, 8'h00, 8'hB0);
    aluCase(8'h5A, 8'h0F, 8'hB0);
    aluCase(8'hFF, 8'h00, 8'h3C);   // INC wraps
    aluCase(8'h10, 8'h00, 8'h3D);
    aluCase(8'h01, 8'h00, 8'h3D);
    emit(8'h76);
  endtask

  task automatic buildRandom(input int n);
    tData        notH [6] = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd5, 8'd7};
    tData        anyReg [7] = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd7};
    tData        aluOps [5] = '{8'd0, 8'd2, 8'd4, 8'd5, 8'd6};
    tData        nops [9] = '{8'h00, 8'h07, 8'h3F, 8'h88, 8'h9E, 8'hB8, 8'h36, 8'h34, 8'h46};
    int          starts [$];
    int          jumpPos [$];
    int          jumpIdx [$];
    logic [2:0]  d;
    logic [2:0]  s;
    logic [15:0] target;
    int          cc;
    prog.delete();
    emitHex(16'h2680, 2);
    for (int i = 0; i < n; i++)
    begin
      starts.push_back(prog.size());
      d = notH[$urandom_range(0, 5)][2:0];
      s = anyReg[$urandom_range(0, 6)][2:0];
      case ($urandom_range(0, 9))
        0:
        begin
          emit({2'b00, d, 3'b110});
          emit(8'($urandom_range(0, 255)));
        end
        1:       emit({2'b01, d, s});
        2:       emit({2'b00, d, 2'b10, 1'($urandom_range(0, 1))});
        3, 4:    emit({2'b10, aluOps[$urandom_range(0, 4)][2:0], s});
        7:
        begin
          cc = $urandom_range(0, 4);
          jumpPos.push_back(prog.size());
          jumpIdx.push_back(i);
          emit(cc == 4 ? 8'hC3 : {3'b110, 2'(cc), 3'b010});
          emit(8'h00);
          emit(8'h00);
        end
        8:       emit(nops[$urandom_range(0, 8)]);
        default: emit({2'b01, 3'b110, s});
      endcase
    end
    starts.push_back(prog.size());
    emit(8'h76);
    // Forward targets on instruction starts only
    foreach (jumpPos[j])
    begin
      target = 16'(starts[$urandom_range(jumpIdx[j] + 1, n)]);
      prog[jumpPos[j] + 1] = target[7:0];
      prog[jumpPos[j] + 2] = target[15:8];
    end
  endtask

  // ----------------------------------------
  task automatic runProgram();
    int   expCount;
    int   cycles;
    tAddr a;
    @(posedge iClock);
    rst <= 1'b1;
    for (int i = 0; i < 65536; i++)
    begin
      a         = 16'(i);
      mem[i]    = a[15:8] ^ a[7:0];
      refMem[i] = mem[i];
    end
    foreach (prog[i])
    begin
      mem[i]    = prog[i];
      refMem[i] = prog[i];
    end
    expCount = runReference();
    if (expCount < 0)
      reportFailure("reference model never reached HALT");
    writeIdx = 0;
    repeat (3) @(posedge iClock);
    rst <= 1'b0;
    cycles = 0;
    @(posedge iClock);
    while (!memRequest.readRequest)
    begin
      checkValue({testName, " writeEnable before fetch"}, 0, 32'(memRequest.writeEnable));
      checkValue({testName, " halted before fetch"}, 0, 32'(halted));
      cycles++;
      if (cycles > 10)
        reportFailure("no opcode fetch after reset");
      @(posedge iClock);
    end
    checkValue({testName, " first fetch addr"}, 0, 32'(memRequest.addr));
    checkValue({testName, " cycles before first fetch"}, 0, 32'(cycles));
    cycles = 0;
    while (!halted)
    begin
      @(posedge iClock);
      cycles++;
      if (cycles > 5000)
        reportFailure("halted never rose");
    end
    repeat (20)
    begin
      @(posedge iClock);
      checkValue({testName, " read after halt"}, 0, 32'(memRequest.readRequest));
      checkValue({testName, " write after halt"}, 0, 32'(memRequest.writeEnable));
      checkValue({testName, " halted held"}, 1, 32'(halted));
    end
    checkValue({testName, " write count"}, 32'(expCount), 32'(writeIdx));
  endtask

  // Compare every DUT write with the next expected one
  always @(posedge iClock)
  begin
    if (!rst && memRequest.writeEnable)
    begin
      if (writeIdx >= expAddr.size())
        reportFailure("DUT wrote more bytes than expected");
      else
      begin
        checkValue($sformatf("%s write %0d addr", testName, writeIdx),
                   32'(expAddr[writeIdx]), 32'(memRequest.addr));
        checkValue($sformatf("%s write %0d data", testName, writeIdx),
                   32'(expData[writeIdx]), 32'(memRequest.writeData));
      end
      writeIdx++;
    end
  end

  initial
  begin
    rst        <= 1'b1;
    readData   <= '0;
    errorCount = 0;
    writeIdx   = 0;
    void'($urandom(32'hbbcc_e7c9));
    testName = "loads";
    buildLoads();
    runProgram();
    testName = "alu";
    buildAlu();
    runProgram();
    for (int p = 0; p < 20; p++)
    begin
      testName = $sformatf("random%0d", p);
      buildRandom(30);
      runProgram();
    end
    if (errorCount == 0)
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
    else
    begin
      $display("SIMULATION FAILED");
      $fatal(1, "Errors found");
    end
  end

endmodule

//--- compile.f
verilog/dzCorePkg.sv
verilog/opcodeDecoder.sv
verilog/sequencer.sv
verilog/registerFile.sv
verilog/aluFlags.sv
verilog/busInterface.sv
verilog/dzCoreTop.sv
testbench/dzCore_properties.sv
testbench/dzCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dzCoreTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)
